//--- trace_prio.f
+incdir+rtl
rtl/trace_prio_pkg.sv
rtl/lead_count.sv
rtl/addr_compressor.sv
rtl/packet_selector.sv
rtl/packet_out_reg.sv
rtl/trace_prio_top.sv
dv/trace_prio_tb.sv

//--- Makefile
# Verilator build and run for the packet-priority stage

VERILATOR  ?= verilator
FLAGS      ?= --timing --assert
TOP        := trace_prio_tb
FILELIST   := trace_prio.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/trace_prio_tb.sv
/*
 * random and directed stimulus for trace_prio_top, checked against an in-bench model
 * fields without meaning for a format are not compared
 */
`timescale 1ns/10ps
`include "trace_prio_config.svh"

module trace_prio_tb;

    import trace_prio_pkg::*;

    localparam int N_RANDOM   = 2000;
    localparam int N_DIRECTED = 20;
    localparam int MAX_CYCLES = 10 * (N_RANDOM + N_DIRECTED);
    localparam int XLEN       = `TRACE_XLEN;
    localparam int KEEP_W     = `TRACE_KEEP_W;

    logic clk_i, rst_ni, valid_i, ready_o, valid_o, ready_i;
    logic lc_exception_i, lc_updiscon_i, tc_qualified_i, tc_exception_i, tc_retired_i;
    logic tc_first_qualified_i, tc_privchange_i, tc_gt_max_resync_i, tc_et_max_resync_i;
    logic tc_branch_map_empty_i, tc_branch_map_full_i, tc_enc_enabled_i, tc_enc_disabled_i;
    logic tc_opmode_change_i, lc_final_qualified_i, nc_exception_i, nc_privchange_i;
    logic nc_branch_map_empty_i, nc_qualified_i, nc_retired_i;
    logic [XLEN-1:0] addr_i;
    packet_format_e  packet_format_o;
    sync_subformat_e sync_subformat_o;
    qual_status_e    qual_status_o;
    logic thaddr_o, lc_tc_mux_o, resync_timer_rst_o;
    logic [KEEP_W-1:0] keep_bits_o;

    // model state and bookkeeping
    logic [14:0] exp_q[$];
    logic [14:0] held;
    logic [14:0] out_now;
    bit    m_reported, m_ended_ntr, m_ended_rep;
    bit    stall_prev, exp_valid_next, rand_ready;
    int    rule_hits[10];
    int    errors, checks, cycles;
    string test_name;

    trace_prio_top dut (.*);

    assign out_now = {packet_format_o, sync_subformat_o, thaddr_o, lc_tc_mux_o,
                      resync_timer_rst_o, qual_status_o, keep_bits_o};

    always #10 clk_i = ~clk_i;

    // hang guard
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic bit chance(input int unsigned pct);
        return $urandom_range(99) < pct;
    endfunction

    // highest bit that differs from the sign, plus the sign bit itself
    function automatic logic [KEEP_W-1:0] expect_keep(input logic [XLEN-1:0] addr);
        int top;
        top = -1;
        for (int i = 0; i < XLEN - 1; i++) begin
            if (addr[i] != addr[XLEN-1]) begin
                top = i;
            end
        end
        return (top < 0) ? '0 : KEEP_W'(top + 2);
    endfunction

    task automatic check_value(input string field, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("FAILED %s: %s expected %0h actual %0h", test_name, field, exp, act);
            errors++;
        end
    endtask

    // priority rules applied to the current input set
    task automatic model_accept(output bit pkt, output logic [14:0] exp);
        bit exc_only, er_n, resync_br, nc_exc_only, nc_ppccd_br, support;
        bit th, mux, rst, ntr_n, rep_n;
        logic [1:0] fmt, sub, qual, br_fmt;
        int rule;
        exc_only    = tc_exception_i && !tc_retired_i;
        er_n        = tc_exception_i && tc_retired_i;
        resync_br   = tc_et_max_resync_i && !tc_branch_map_empty_i;
        nc_exc_only = nc_exception_i && !nc_retired_i;
        nc_ppccd_br = nc_privchange_i && !nc_branch_map_empty_i;
        support     = tc_enc_enabled_i || tc_enc_disabled_i || tc_opmode_change_i ||
                      lc_final_qualified_i;
        br_fmt = tc_branch_map_empty_i ? F_ADDR_ONLY : F_DIFF_DELTA;
        pkt  = 1'b1;
        fmt  = F_SYNC;
        sub  = SF_START;
        qual = NO_CHANGE;
        th    = 1'b0;
        mux   = 1'b0;
        ntr_n = 1'b0;
        rep_n = 1'b0;
        if (support) begin
            rule = 1;
            sub  = SF_SUPPORT;
            qual = m_ended_ntr ? ENDED_NTR : (m_ended_rep ? ENDED_REP : NO_CHANGE);
        end else if (!tc_qualified_i) begin
            rule = 2;
            pkt  = 1'b0;
        end else if (lc_exception_i) begin
            rule = 3;
            if (exc_only) begin
                sub        = SF_TRAP;
                m_reported = 1'b1;
            end else if (m_reported) begin
                m_reported = 1'b0;
            end else begin
                sub = SF_TRAP;
                th  = 1'b1;
            end
        end else if (tc_first_qualified_i || tc_privchange_i || tc_gt_max_resync_i) begin
            rule = 4;
            if (!exc_only) begin
                m_reported = 1'b0;
            end
        end else if (lc_updiscon_i) begin
            rule  = 5;
            ntr_n = 1'b1;
            if (exc_only) begin
                sub        = SF_TRAP;
                mux        = 1'b1;
                m_reported = 1'b0;
            end else begin
                fmt = br_fmt;
            end
        end else if (resync_br || er_n) begin
            rule = 6;
            fmt  = br_fmt;
        end else if (nc_exc_only || nc_ppccd_br || !nc_qualified_i) begin
            rule  = 7;
            rep_n = !nc_qualified_i;
            fmt   = br_fmt;
        end else if (tc_branch_map_full_i) begin
            rule = 8;
            fmt  = F_DIFF_DELTA;
        end else begin
            rule = 9;
            pkt  = 1'b0;
        end
        rst = pkt && fmt == F_SYNC && sub != SF_SUPPORT;
        m_ended_ntr = ntr_n;
        m_ended_rep = rep_n;
        rule_hits[rule] = rule_hits[rule] + 1;
        exp = {fmt, sub, th, mux, rst, qual, expect_keep(addr_i)};
    endtask

    // compares on transfers, watches stalls and latency, runs the model on accepts
    always @(posedge clk_i) begin
        logic [1:0] e_fmt, e_sub, e_qual;
        logic e_th, e_mux, e_rst;
        logic [KEEP_W-1:0] e_keep;
        logic [14:0] exp;
        bit pkt;
        if (rst_ni) begin
            if (exp_valid_next) begin
                assert (valid_o) else begin
                    $display("%s: valid_o did not rise one cycle after a packet was accepted",
                             test_name);
                    errors++;
                end
            end
            if (stall_prev) begin
                assert (out_now == held) else begin
                    $display("%s: output fields changed while valid_o was high and ready_i low",
                             test_name);
                    errors++;
                end
            end
            if (valid_o && ready_i) begin
                assert (exp_q.size() > 0) else begin
                    $display("%s: packet transferred with none expected", test_name);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    {e_fmt, e_sub, e_th, e_mux, e_rst, e_qual, e_keep} = exp_q.pop_front();
                    check_value("format", int'(e_fmt), int'(packet_format_o));
                    check_value("resync_rst", int'(e_rst), int'(resync_timer_rst_o));
                    check_value("keep_bits", int'(e_keep), int'(keep_bits_o));
                    if (e_fmt == F_SYNC) begin
                        check_value("subformat", int'(e_sub), int'(sync_subformat_o));
                    end
                    if (e_fmt == F_SYNC && e_sub == SF_TRAP) begin
                        check_value("thaddr", int'(e_th), int'(thaddr_o));
                        check_value("lc_tc_mux", int'(e_mux), int'(lc_tc_mux_o));
                    end
                    if (e_fmt == F_SYNC && e_sub == SF_SUPPORT) begin
                        check_value("qual_status", int'(e_qual), int'(qual_status_o));
                    end
                end
            end
            stall_prev     = valid_o && !ready_i;
            held           = out_now;
            exp_valid_next = 1'b0;
            if (valid_i && ready_o) begin
                model_accept(pkt, exp);
                if (pkt) begin
                    exp_q.push_back(exp);
                    exp_valid_next = 1'b1;
                end
            end
        end
    end

    // all flags low except qualification, a set that yields no packet
    task automatic quiet_set(input logic [XLEN-1:0] addr);
        {lc_exception_i, lc_updiscon_i, tc_exception_i, tc_retired_i} = '0;
        {tc_first_qualified_i, tc_privchange_i, tc_gt_max_resync_i, tc_et_max_resync_i} = '0;
        {tc_branch_map_full_i, tc_enc_enabled_i, tc_enc_disabled_i} = '0;
        {tc_opmode_change_i, lc_final_qualified_i, nc_exception_i, nc_privchange_i} = '0;
        {tc_qualified_i, nc_qualified_i, tc_branch_map_empty_i, nc_branch_map_empty_i} = '1;
        nc_retired_i = 1'b0;
        addr_i = addr;
    endtask

    // biased so that every priority rule shows up
    task automatic randomize_set();
        lc_exception_i        = chance(20);
        lc_updiscon_i         = chance(20);
        tc_qualified_i        = chance(85);
        tc_exception_i        = chance(25);
        tc_retired_i          = chance(50);
        tc_first_qualified_i  = chance(5);
        tc_privchange_i       = chance(5);
        tc_gt_max_resync_i    = chance(5);
        tc_et_max_resync_i    = chance(20);
        tc_branch_map_empty_i = chance(50);
        tc_branch_map_full_i  = chance(30);
        tc_enc_enabled_i      = chance(3);
        tc_enc_disabled_i     = chance(3);
        tc_opmode_change_i    = chance(3);
        lc_final_qualified_i  = chance(3);
        nc_exception_i        = chance(15);
        nc_privchange_i       = chance(10);
        nc_branch_map_empty_i = chance(50);
        nc_qualified_i        = chance(85);
        nc_retired_i          = chance(50);
        case ($urandom_range(5))
            0: addr_i = '0;
            1: addr_i = '1;
            2: addr_i = $urandom >> $urandom_range(31);
            3: addr_i = ~($urandom >> $urandom_range(31));
            default: addr_i = $urandom;
        endcase
    endtask

    // hold the set until accepted, inputs change 2 ns after the edge
    task automatic send_set();
        bit took;
        valid_i = 1'b1;
        do begin
            @(posedge clk_i);
            took = ready_o;
            #2;
            if (rand_ready) begin
                ready_i = chance(70);
            end
        end while (!took);
        valid_i = 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk_i);
        #2;
        ready_i = rand_ready ? chance(70) : 1'b1;
    endtask

    task automatic end_test(input int err_base, input int chk_base);
        $display("test %s: %0d checks, %0d errors", test_name, checks - chk_base,
                 errors - err_base);
    endtask

    initial begin
        int err_base;
        int chk_base;
        logic [XLEN-1:0] addrs[6];
        void'($urandom(89));
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        valid_i    = 1'b0;
        // sink stalled, so ready_o can only come from the empty register
        ready_i    = 1'b0;
        rand_ready = 1'b0;
        quiet_set('0);

        test_name = "reset";
        err_base  = errors;
        chk_base  = checks;
        repeat (4) @(posedge clk_i);
        check_value("valid_o in reset", 0, int'(valid_o));
        check_value("ready_o in reset", 1, int'(ready_o));
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_value("valid_o after reset", 0, int'(valid_o));
        check_value("ready_o after reset", 1, int'(ready_o));
        @(posedge clk_i);
        #2;
        ready_i = 1'b1;
        end_test(err_base, chk_base);

        test_name = "directed";
        err_base  = errors;
        chk_base  = checks;
        // support with no history, then after updiscon and after unqualified next
        quiet_set(32'h0000_1000);
        tc_enc_enabled_i = 1'b1;
        send_set();
        quiet_set(32'h0000_2000);
        lc_updiscon_i = 1'b1;
        send_set();
        quiet_set(32'h0000_3000);
        lc_final_qualified_i = 1'b1;
        send_set();
        quiet_set(32'hFFFF_F000);
        nc_qualified_i = 1'b0;
        send_set();
        quiet_set(32'h0000_4000);
        tc_opmode_change_i = 1'b1;
        send_set();
        // trap without address, start once reported, then trap with address
        quiet_set(32'h8000_0010);
        lc_exception_i = 1'b1;
        tc_exception_i = 1'b1;
        send_set();
        quiet_set(32'h8000_0020);
        lc_exception_i = 1'b1;
        send_set();
        quiet_set(32'h8000_0030);
        lc_exception_i = 1'b1;
        send_set();
        quiet_set(32'h0000_0100);
        tc_first_qualified_i = 1'b1;
        send_set();
        quiet_set(32'h0000_0200);
        lc_updiscon_i  = 1'b1;
        tc_exception_i = 1'b1;
        send_set();
        quiet_set(32'h0000_0300);
        tc_qualified_i = 1'b0;
        tc_branch_map_full_i = 1'b1;
        send_set();
        // compression corners through branch-map-full packets
        addrs = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000,
                  32'h0000_0001, 32'hFFFF_FFFE};
        foreach (addrs[i]) begin
            quiet_set(addrs[i]);
            tc_branch_map_full_i = 1'b1;
            send_set();
        end
        repeat (3) idle_cycle();
        end_test(err_base, chk_base);

        test_name  = "random";
        err_base   = errors;
        chk_base   = checks;
        rand_ready = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            if (chance(10)) begin
                idle_cycle();
            end
            randomize_set();
            send_set();
        end
        // drain with the sink always ready
        rand_ready = 1'b0;
        ready_i    = 1'b1;
        while (exp_q.size() > 0 || valid_o) begin
            idle_cycle();
        end
        for (int r = 1; r <= 9; r++) begin
            assert (rule_hits[r] > 0) else begin
                $display("random: priority rule %0d was never exercised", r);
                errors++;
            end
        end
        end_test(err_base, chk_base);

        $display("summary: 3 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/trace_prio_top.sv
/*
 * packet-priority stage, one register between valid/ready input and output
 * accepted sets without a packet still advance the selector state
 */
`timescale 1ns/10ps
`include "trace_prio_config.svh"

module trace_prio_top (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // input handshake
    input  logic                             valid_i,
    output logic                             ready_o,
    input  logic                             lc_exception_i,
    input  logic                             lc_updiscon_i,
    input  logic                             tc_qualified_i,
    input  logic                             tc_exception_i,
    input  logic                             tc_retired_i,
    input  logic                             tc_first_qualified_i,
    input  logic                             tc_privchange_i,
    input  logic                             tc_gt_max_resync_i,
    input  logic                             tc_et_max_resync_i,
    input  logic                             tc_branch_map_empty_i,
    input  logic                             tc_branch_map_full_i,
    input  logic                             tc_enc_enabled_i,
    input  logic                             tc_enc_disabled_i,
    input  logic                             tc_opmode_change_i,
    input  logic                             lc_final_qualified_i,
    input  logic                             nc_exception_i,
    input  logic                             nc_privchange_i,
    input  logic                             nc_branch_map_empty_i,
    input  logic                             nc_qualified_i,
    input  logic                             nc_retired_i,
    input  logic [`TRACE_XLEN-1:0]           addr_i,
    // output handshake
    output logic                             valid_o,
    input  logic                             ready_i,
    output trace_prio_pkg::packet_format_e   packet_format_o,
    output trace_prio_pkg::sync_subformat_e  sync_subformat_o,
    output logic                             thaddr_o,
    output logic                             lc_tc_mux_o,
    output logic                             resync_timer_rst_o,
    output trace_prio_pkg::qual_status_e     qual_status_o,
    output logic [`TRACE_KEEP_W-1:0]         keep_bits_o
);

    import trace_prio_pkg::*;

    logic            accept;
    logic            pkt;
    packet_format_e  sel_format;
    sync_subformat_e sel_subformat;
    logic            sel_thaddr;
    logic            sel_lc_tc_mux;
    logic            sel_resync_rst;
    qual_status_e    sel_qual_status;
    logic [`TRACE_KEEP_W-1:0] keep_bits;

    assign accept = valid_i && ready_o;

    packet_selector i_selector (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .accept_i              (accept),
        .lc_exception_i        (lc_exception_i),
        .lc_updiscon_i         (lc_updiscon_i),
        .tc_qualified_i        (tc_qualified_i),
        .tc_exception_i        (tc_exception_i),
        .tc_retired_i          (tc_retired_i),
        .tc_first_qualified_i  (tc_first_qualified_i),
        .tc_privchange_i       (tc_privchange_i),
        .tc_gt_max_resync_i    (tc_gt_max_resync_i),
        .tc_et_max_resync_i    (tc_et_max_resync_i),
        .tc_branch_map_empty_i (tc_branch_map_empty_i),
        .tc_branch_map_full_i  (tc_branch_map_full_i),
        .tc_enc_enabled_i      (tc_enc_enabled_i),
        .tc_enc_disabled_i     (tc_enc_disabled_i),
        .tc_opmode_change_i    (tc_opmode_change_i),
        .lc_final_qualified_i  (lc_final_qualified_i),
        .nc_exception_i        (nc_exception_i),
        .nc_privchange_i       (nc_privchange_i),
        .nc_branch_map_empty_i (nc_branch_map_empty_i),
        .nc_qualified_i        (nc_qualified_i),
        .nc_retired_i          (nc_retired_i),
        .pkt_o                 (pkt),
        .format_o              (sel_format),
        .subformat_o           (sel_subformat),
        .thaddr_o              (sel_thaddr),
        .lc_tc_mux_o           (sel_lc_tc_mux),
        .resync_rst_o          (sel_resync_rst),
        .qual_status_o         (sel_qual_status)
    );

    addr_compressor i_compressor (
        .addr_i      (addr_i),
        .keep_bits_o (keep_bits)
    );

    // only packet-producing sets occupy the register
    packet_out_reg i_out_reg (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .load_i        (accept && pkt),
        .format_i      (sel_format),
        .subformat_i   (sel_subformat),
        .thaddr_i      (sel_thaddr),
        .lc_tc_mux_i   (sel_lc_tc_mux),
        .resync_rst_i  (sel_resync_rst),
        .qual_status_i (sel_qual_status),
        .keep_bits_i   (keep_bits),
        .ready_i       (ready_i),
        .valid_o       (valid_o),
        .ready_o       (ready_o),
        .format_o      (packet_format_o),
        .subformat_o   (sync_subformat_o),
        .thaddr_o      (thaddr_o),
        .lc_tc_mux_o   (lc_tc_mux_o),
        .resync_rst_o  (resync_timer_rst_o),
        .qual_status_o (qual_status_o),
        .keep_bits_o   (keep_bits_o)
    );

endmodule

//--- rtl/packet_out_reg.sv
/*
 * one-entry output register, ready_o depends combinationally on ready_i
 * fields hold while valid_o is high and ready_i is low
 */
`timescale 1ns/10ps
`include "trace_prio_config.svh"

module packet_out_reg (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             load_i,
    input  trace_prio_pkg::packet_format_e   format_i,
    input  trace_prio_pkg::sync_subformat_e  subformat_i,
    input  logic                             thaddr_i,
    input  logic                             lc_tc_mux_i,
    input  logic                             resync_rst_i,
    input  trace_prio_pkg::qual_status_e     qual_status_i,
    input  logic [`TRACE_KEEP_W-1:0]         keep_bits_i,
    input  logic                             ready_i,
    output logic                             valid_o,
    output logic                             ready_o,
    output trace_prio_pkg::packet_format_e   format_o,
    output trace_prio_pkg::sync_subformat_e  subformat_o,
    output logic                             thaddr_o,
    output logic                             lc_tc_mux_o,
    output logic                             resync_rst_o,
    output trace_prio_pkg::qual_status_e     qual_status_o,
    output logic [`TRACE_KEEP_W-1:0]         keep_bits_o
);

    import trace_prio_pkg::*;

    logic valid_q;

    // empty, or draining this cycle
    assign ready_o = !valid_q || ready_i;
    assign valid_o = valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            format_o      <= format_i;
            subformat_o   <= subformat_i;
            thaddr_o      <= thaddr_i;
            lc_tc_mux_o   <= lc_tc_mux_i;
            resync_rst_o  <= resync_rst_i;
            qual_status_o <= qual_status_i;
            keep_bits_o   <= keep_bits_i;
        end
    end

    // stalled packet stays put
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_o && !ready_i |=> valid_o && $stable({format_o, subformat_o, thaddr_o,
            lc_tc_mux_o, resync_rst_o, qual_status_o, keep_bits_o}))
        else $error("packet_out_reg: output changed under back-pressure");

endmodule

//--- rtl/packet_selector.sv
/*
 * packet priority decision for one accepted lc/tc/nc flag set
 * fields are only meaningful while pkt_o is high, state moves only on accept_i
 */
`timescale 1ns/10ps
`include "trace_prio_config.svh"

module packet_selector (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             accept_i,
    // last cycle
    input  logic                             lc_exception_i,
    input  logic                             lc_updiscon_i,
    // this cycle
    input  logic                             tc_qualified_i,
    input  logic                             tc_exception_i,
    input  logic                             tc_retired_i,
    input  logic                             tc_first_qualified_i,
    input  logic                             tc_privchange_i,
    input  logic                             tc_gt_max_resync_i,
    input  logic                             tc_et_max_resync_i,
    input  logic                             tc_branch_map_empty_i,
    input  logic                             tc_branch_map_full_i,
    // support packet triggers
    input  logic                             tc_enc_enabled_i,
    input  logic                             tc_enc_disabled_i,
    input  logic                             tc_opmode_change_i,
    input  logic                             lc_final_qualified_i,
    // next cycle
    input  logic                             nc_exception_i,
    input  logic                             nc_privchange_i,
    input  logic                             nc_branch_map_empty_i,
    input  logic                             nc_qualified_i,
    input  logic                             nc_retired_i,
    // decision
    output logic                             pkt_o,
    output trace_prio_pkg::packet_format_e   format_o,
    output trace_prio_pkg::sync_subformat_e  subformat_o,
    output logic                             thaddr_o,
    output logic                             lc_tc_mux_o,
    output logic                             resync_rst_o,
    output trace_prio_pkg::qual_status_e     qual_status_o
);

    import trace_prio_pkg::*;

    // derived cycle conditions
    logic exc_only;
    logic er_n;
    logic resync_br;
    logic nc_exc_only;
    logic nc_ppccd_br;
    logic support_evt;

    // state across accepted sets
    logic reported_d, reported_q;
    logic reported_upd;
    logic ended_ntr_d, ended_ntr_q;
    logic ended_rep_d, ended_rep_q;

    packet_format_e br_fmt;

    assign exc_only    = tc_exception_i && !tc_retired_i;
    assign er_n        = tc_exception_i && tc_retired_i;
    assign resync_br   = tc_et_max_resync_i && !tc_branch_map_empty_i;
    assign nc_exc_only = nc_exception_i && !nc_retired_i;
    assign nc_ppccd_br = nc_privchange_i && !nc_branch_map_empty_i;
    assign support_evt = tc_enc_enabled_i || tc_enc_disabled_i || tc_opmode_change_i ||
                         lc_final_qualified_i;

    // format 1 with branches pending, otherwise address only
    assign br_fmt = tc_branch_map_empty_i ? F_ADDR_ONLY : F_DIFF_DELTA;

    always_comb begin
        pkt_o         = 1'b0;
        format_o      = F_OPT_EXT;
        subformat_o   = SF_START;
        thaddr_o      = 1'b0;
        lc_tc_mux_o   = 1'b0;
        qual_status_o = NO_CHANGE;
        reported_d    = 1'b0;
        ended_ntr_d   = 1'b0;
        ended_rep_d   = 1'b0;

        if (accept_i) begin
            if (support_evt) begin
                pkt_o       = 1'b1;
                format_o    = F_SYNC;
                subformat_o = SF_SUPPORT;
                // ntr ending takes precedence over rep
                if (ended_ntr_q) begin
                    qual_status_o = ENDED_NTR;
                end else if (ended_rep_q) begin
                    qual_status_o = ENDED_REP;
                end
            end else if (tc_qualified_i) begin
                pkt_o = 1'b1;
                if (lc_exception_i) begin
                    format_o = F_SYNC;
                    if (exc_only) begin
                        // trap without an address, mark it reported
                        subformat_o = SF_TRAP;
                        reported_d  = 1'b1;
                    end else if (reported_q) begin
                        subformat_o = SF_START;
                    end else begin
                        subformat_o = SF_TRAP;
                        thaddr_o    = 1'b1;
                    end
                end else if (tc_first_qualified_i || tc_privchange_i || tc_gt_max_resync_i) begin
                    format_o    = F_SYNC;
                    subformat_o = SF_START;
                end else if (lc_updiscon_i) begin
                    ended_ntr_d = 1'b1;
                    if (exc_only) begin
                        // cause and tval come from this cycle
                        format_o    = F_SYNC;
                        subformat_o = SF_TRAP;
                        lc_tc_mux_o = 1'b1;
                    end else begin
                        format_o = br_fmt;
                    end
                end else if (resync_br || er_n) begin
                    format_o = br_fmt;
                end else if (nc_exc_only || nc_ppccd_br || !nc_qualified_i) begin
                    // last qualified instruction before trace stops
                    ended_rep_d = !nc_qualified_i;
                    format_o    = br_fmt;
                end else if (tc_branch_map_full_i) begin
                    format_o = F_DIFF_DELTA;
                end else begin
                    pkt_o = 1'b0;
                end
            end
        end
    end

    // every sync packet except support restarts the resync timer
    assign resync_rst_o = pkt_o && format_o == F_SYNC && subformat_o != SF_SUPPORT;

    // reported follows traps without address and starts outside exc_only
    assign reported_upd = pkt_o && format_o == F_SYNC &&
                          ((subformat_o == SF_TRAP && !thaddr_o) ||
                           (subformat_o == SF_START && !exc_only));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reported_q  <= 1'b0;
            ended_ntr_q <= 1'b0;
            ended_rep_q <= 1'b0;
        end else if (accept_i) begin
            if (reported_upd) begin
                reported_q <= reported_d;
            end
            ended_ntr_q <= ended_ntr_d;
            ended_rep_q <= ended_rep_d;
        end
    end

    // reported only rises through an exception-only trap
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(reported_q) |-> $past(accept_i && tc_qualified_i && !support_evt &&
                                    lc_exception_i && exc_only))
        else $error("packet_selector: reported set outside an exception-only trap");

endmodule

//--- rtl/addr_compressor.sv
/*
 * number of low address bits to send, one sign bit included
 * result is 0 for an all-zero or all-one address
 */
`timescale 1ns/10ps
`include "trace_prio_config.svh"

module addr_compressor (
    input  logic [`TRACE_XLEN-1:0]   addr_i,
    output logic [`TRACE_KEEP_W-1:0] keep_bits_o
);

    localparam int unsigned KEEP_W = `TRACE_KEEP_W;

    logic [`TRACE_CNT_W-1:0] lead_zeros;
    logic [`TRACE_CNT_W-1:0] lead_ones;
    logic [`TRACE_CNT_W-1:0] lead_max;
    logic                    all_zeros;
    logic                    all_ones;

    // leading zeros of the address
    lead_count #(
        .WIDTH (`TRACE_XLEN)
    ) i_count_zeros (
        .in_i    (addr_i),
        .cnt_o   (lead_zeros),
        .empty_o (all_zeros)
    );

    // leading ones, counted as zeros of the inverse
    lead_count #(
        .WIDTH (`TRACE_XLEN)
    ) i_count_ones (
        .in_i    (~addr_i),
        .cnt_o   (lead_ones),
        .empty_o (all_ones)
    );

    // drop whichever run is longer
    assign lead_max = (lead_zeros > lead_ones) ? lead_zeros : lead_ones;

    // keep one copy of the sign bit for sign extension
    assign keep_bits_o = (all_zeros || all_ones) ? '0 :
                         KEEP_W'(`TRACE_XLEN) - KEEP_W'(lead_max) + KEEP_W'(1);

endmodule

//--- rtl/lead_count.sv
/*
 * leading zero counter, WIDTH must be a power of two and at least 2
 * cnt_o reads 0 when the input is all zeros, check empty_o first
 */
`timescale 1ns/10ps
`include "trace_prio_config.svh"

module lead_count #(
    parameter int unsigned WIDTH = `TRACE_XLEN
) (
    input  logic [WIDTH-1:0]         in_i,
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    output logic                     empty_o
);

    localparam int unsigned CNT_W = $clog2(WIDTH);

    logic [CNT_W-1:0] cnt;

    // scan upwards, so the highest set bit wins
    always_comb begin
        cnt = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (in_i[i]) begin
                cnt = CNT_W'(WIDTH - 1 - i);
            end
        end
        // only the leading one may survive the shift, zeros above it
        if (|in_i) begin
            assert ((in_i >> (CNT_W'(WIDTH - 1) - cnt)) == WIDTH'(1))
                else $error("lead_count: count %0d does not hit the leading one", cnt);
        end
    end

    assign cnt_o   = cnt;
    assign empty_o = ~|in_i;

endmodule

//--- rtl/trace_prio_pkg.sv
/*
 * packet field encodings of the trace encoder
 * context subformat and trace-lost status are not supported, their codes stay unused
 */
package trace_prio_pkg;

    // te_inst packet format
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } packet_format_e;

    // subformat of a format 3 packet
    // code 2 would be the context subformat
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_SUPPORT = 2'h3
    } sync_subformat_e;

    // qualification status carried by support packets
    // code 2 would be trace lost
    typedef enum logic [1:0] {
        NO_CHANGE = 2'h0,
        ENDED_REP = 2'h1,
        ENDED_NTR = 2'h3
    } qual_status_e;

endpackage

//--- rtl/trace_prio_config.svh
/*
 * widths shared by the packet-priority stage and its testbench
 * TRACE_CNT_W must stay log2 of TRACE_XLEN, TRACE_KEEP_W one more than that
 */
`ifndef TRACE_PRIO_CONFIG_SVH
`define TRACE_PRIO_CONFIG_SVH

// instruction address width
`define TRACE_XLEN 32

// leading zero/one count width
`define TRACE_CNT_W 5

// keep_bits width, must hold TRACE_XLEN + 1
`define TRACE_KEEP_W 6

`endif
